// ==== r8051_pkg.sv ====
package r8051_pkg;

    localparam int BYTE_W      = 8;
    localparam int CODE_ADDR_W = 16;

    typedef logic [BYTE_W-1:0]      byte_t;
    typedef logic [CODE_ADDR_W-1:0] code_addr_t;
    // bit 7 set selects sfr space
    typedef logic [BYTE_W-1:0]      data_addr_t;

    localparam data_addr_t SFR_ACC = 8'hE0;
    localparam data_addr_t SFR_PSW = 8'hD0;

    localparam int PSW_C  = 7;
    localparam int PSW_AC = 6;
    localparam int PSW_OV = 2;
    localparam int PSW_P  = 0;

    // one byte
    localparam byte_t OP_NOP         = 8'h00;
    localparam byte_t OP_INC_A       = 8'h04;
    localparam byte_t OP_CLR_C       = 8'hC3;
    localparam byte_t OP_SETB_C      = 8'hD3;
    localparam byte_t OP_CLR_A       = 8'hE4;
    localparam byte_t OP_CPL_A       = 8'hF4;
    // two bytes
    localparam byte_t OP_ADD_IMM     = 8'h24;
    localparam byte_t OP_ADD_DIR     = 8'h25;
    localparam byte_t OP_ADDC_IMM    = 8'h34;
    localparam byte_t OP_SUBB_IMM    = 8'h94;
    localparam byte_t OP_ANL_IMM     = 8'h54;
    localparam byte_t OP_ORL_IMM     = 8'h44;
    localparam byte_t OP_XRL_IMM     = 8'h64;
    localparam byte_t OP_MOV_A_IMM   = 8'h74;
    localparam byte_t OP_MOV_A_DIR   = 8'hE5;
    localparam byte_t OP_MOV_DIR_A   = 8'hF5;
    localparam byte_t OP_JC          = 8'h40;
    localparam byte_t OP_JNC         = 8'h50;
    // three bytes
    localparam byte_t OP_MOV_DIR_IMM = 8'h75;

    function automatic logic is_len2(byte_t op);
        return op inside {OP_ADD_IMM, OP_ADD_DIR, OP_ADDC_IMM, OP_SUBB_IMM,
                          OP_ANL_IMM, OP_ORL_IMM, OP_XRL_IMM, OP_MOV_A_IMM,
                          OP_MOV_A_DIR, OP_MOV_DIR_A, OP_JC, OP_JNC};
    endfunction

    function automatic logic is_len3(byte_t op);
        return op == OP_MOV_DIR_IMM;
    endfunction

    function automatic logic reads_dir_b(byte_t op);
        return op inside {OP_ADD_DIR, OP_MOV_A_DIR};
    endfunction

    function automatic logic writes_dir_b(byte_t op);
        return op == OP_MOV_DIR_A;
    endfunction

    function automatic logic writes_dir_c(byte_t op);
        return op == OP_MOV_DIR_IMM;
    endfunction

    function automatic logic is_branch(byte_t op);
        return op inside {OP_JC, OP_JNC};
    endfunction

endpackage

// ==== r8051_pipe_if.sv ====
`timescale 1ns/1ps

interface pipe_if import r8051_pkg::*; ();

    // stage advance held low while a data read is outstanding
    logic  work_en;
    // raw code bytes
    byte_t cmd0;
    byte_t cmd1;
    // opcode per stage or zero for an operand byte
    byte_t cmda;
    byte_t cmdb;
    byte_t cmdc;

    modport fetch (
        output work_en, cmd0, cmd1, cmda, cmdb, cmdc
    );

    modport stage (
        input work_en, cmd0, cmd1, cmda, cmdb, cmdc
    );

endinterface

// ==== r8051_fetch.sv ====
`timescale 1ns/1ps

module r8051_fetch import r8051_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_en,
    input  logic       cpu_restart,
    input  byte_t      rom_byte,
    input  logic       ram_rd_req,
    input  logic       ram_rd_vld,
    input  logic       psw_c,
    output logic       rom_en,
    output code_addr_t rom_addr,
    pipe_if.fetch      pipe
);

    logic       rd_wait;
    byte_t      cmd1;
    byte_t      cmd2;
    logic [2:0] cmd_flag;
    code_addr_t pc;
    code_addr_t code_addr;
    logic       branch_taken;

    // a request made while advancing always waits for its valid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_wait <= 1'b0;
        end else if (cpu_restart) begin
            rd_wait <= 1'b0;
        end else if (pipe.work_en) begin
            rd_wait <= ram_rd_req;
        end
    end

    assign pipe.work_en = (rd_wait && !ram_rd_vld) ? 1'b0 : cpu_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd1 <= '0;
            cmd2 <= '0;
        end else if (cpu_restart) begin
            cmd2 <= '0;
        end else if (pipe.work_en) begin
            cmd1 <= rom_byte;
            cmd2 <= pipe.cmdb;
        end
    end

    // bit 0 marks the byte being fetched as an opcode
    // bits 1 and 2 do the same for cmd0 and cmd1
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_flag <= 3'b001;
        end else if (cpu_restart) begin
            cmd_flag <= 3'b001;
        end else if (pipe.work_en) begin
            if (is_len2(pipe.cmda)) begin
                cmd_flag <= 3'b101;
            end else if (is_len3(pipe.cmda)) begin
                cmd_flag <= 3'b100;
            end else begin
                cmd_flag <= {cmd_flag[1:0], 1'b1};
            end
        end
    end

    assign pipe.cmd0 = rom_byte;
    assign pipe.cmd1 = cmd1;
    assign pipe.cmda = cmd_flag[1] ? rom_byte : '0;
    assign pipe.cmdb = cmd_flag[2] ? cmd1 : '0;
    assign pipe.cmdc = cmd2;

    // pc already points past the offset byte
    assign code_addr = pc + {{(CODE_ADDR_W-BYTE_W){rom_byte[7]}}, rom_byte};

    // jnc differs from jc only in opcode bit 4
    assign branch_taken = is_branch(pipe.cmdb) && (psw_c ^ pipe.cmdb[4]);

    assign rom_addr = branch_taken ? code_addr : pc;
    assign rom_en   = pipe.work_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (cpu_restart) begin
            pc <= '0;
        end else if (pipe.work_en) begin
            pc <= rom_addr + 16'd1;
        end
    end

endmodule

// ==== r8051_mem_access.sv ====
`timescale 1ns/1ps

module r8051_mem_access import r8051_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    pipe_if.stage      pipe,
    input  byte_t      acc,
    input  byte_t      psw,
    input  byte_t      ram_rd_byte,
    output logic       ram_rd_en_data,
    output logic       ram_rd_en_sfr,
    output logic       ram_wr_en_data,
    output logic       ram_wr_en_sfr,
    output data_addr_t ram_rd_addr,
    output data_addr_t ram_wr_addr,
    output byte_t      ram_wr_byte,
    output byte_t      data0,
    output byte_t      wr_byte,
    output logic       wr_acc_sfr,
    output logic       wr_psw_sfr
);

    logic       rd_en;
    logic       rd_en_data;
    logic       rd_en_sfr;
    data_addr_t rd_addr;
    logic       read_internal;
    logic       wr_en_b;
    logic       wr_en_c;
    logic       wr_en_data;
    logic       wr_en_sfr;
    data_addr_t wr_addr;
    logic       write_internal;
    logic       same_flag_data;
    logic       same_flag_sfr;
    logic       same_flag;
    byte_t      same_byte;

    // direct address follows the opcode in stage b
    assign rd_en      = reads_dir_b(pipe.cmdb);
    assign rd_addr    = rd_en ? pipe.cmd0 : '0;
    assign rd_en_data = rd_en & ~rd_addr[7];
    assign rd_en_sfr  = rd_en & rd_addr[7];

    assign read_internal = rd_en_sfr & ((rd_addr == SFR_ACC) | (rd_addr == SFR_PSW));

    assign wr_en_b = writes_dir_b(pipe.cmdb);
    assign wr_en_c = writes_dir_c(pipe.cmdc);

    always_comb begin
        if (wr_en_c) begin
            wr_addr = pipe.cmd1;
            wr_byte = pipe.cmd0;
        end else if (wr_en_b) begin
            wr_addr = pipe.cmd0;
            wr_byte = acc;
        end else begin
            wr_addr = '0;
            wr_byte = '0;
        end
    end

    assign wr_en_data = (wr_en_b | wr_en_c) & ~wr_addr[7];
    assign wr_en_sfr  = (wr_en_b | wr_en_c) & wr_addr[7];

    assign wr_acc_sfr     = wr_en_sfr & (wr_addr == SFR_ACC);
    assign wr_psw_sfr     = wr_en_sfr & (wr_addr == SFR_PSW);
    assign write_internal = wr_acc_sfr | wr_psw_sfr;

    // same space and address as this cycle's write
    assign same_flag_data = rd_en_data & wr_en_data & (rd_addr == wr_addr);
    assign same_flag_sfr  = rd_en_sfr & wr_en_sfr & (rd_addr == wr_addr);

    assign ram_rd_en_data = pipe.work_en & rd_en_data & ~same_flag_data;
    assign ram_rd_en_sfr  = pipe.work_en & rd_en_sfr & ~same_flag_sfr & ~read_internal;
    assign ram_rd_addr    = rd_addr;

    assign ram_wr_en_data = pipe.work_en & wr_en_data;
    assign ram_wr_en_sfr  = pipe.work_en & wr_en_sfr & ~write_internal;
    assign ram_wr_addr    = wr_addr;
    assign ram_wr_byte    = wr_byte;

    // without forwarding, same_byte holds a one-hot internal source select
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            same_flag <= 1'b0;
            same_byte <= '0;
        end else if (pipe.work_en) begin
            same_flag <= same_flag_data | same_flag_sfr;
            if (same_flag_data | same_flag_sfr) begin
                same_byte <= wr_byte;
            end else if (read_internal && (rd_addr == SFR_ACC)) begin
                same_byte <= 8'h80;
            end else if (read_internal) begin
                same_byte <= 8'h40;
            end else begin
                same_byte <= '0;
            end
        end
    end

    always_comb begin
        if (same_flag) begin
            data0 = same_byte;
        end else if (same_byte[7]) begin
            data0 = acc;
        end else if (same_byte[6]) begin
            data0 = psw;
        end else begin
            data0 = ram_rd_byte;
        end
    end

endmodule

// ==== r8051_exec.sv ====
`timescale 1ns/1ps

module r8051_exec import r8051_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    pipe_if.stage pipe,
    input  byte_t data0,
    input  byte_t wr_byte,
    input  logic  wr_acc_sfr,
    input  logic  wr_psw_sfr,
    output byte_t acc,
    output byte_t psw,
    output logic  psw_c
);

    logic       op_add;
    logic       op_add_dir;
    logic       op_addc;
    logic       op_subb;
    logic       op_inc;
    logic       arith_flags;
    byte_t      add_b;
    logic       add_c;
    logic [4:0] low_sum;
    logic [3:0] mid_sum;
    logic [1:0] top_sum;
    byte_t      add_byte;
    logic       bit_ov;
    byte_t      and_out;
    byte_t      or_out;
    byte_t      xor_out;
    logic       psw_ac;
    logic       psw_ov;
    logic [3:0] psw_other;

    assign op_add      = pipe.cmdb == OP_ADD_IMM;
    assign op_add_dir  = pipe.cmdc == OP_ADD_DIR;
    assign op_addc     = pipe.cmdb == OP_ADDC_IMM;
    assign op_subb     = pipe.cmdb == OP_SUBB_IMM;
    assign op_inc      = pipe.cmdb == OP_INC_A;
    assign arith_flags = op_add | op_add_dir | op_addc | op_subb;

    assign add_b = op_add_dir ? data0 : (op_inc ? '0 : pipe.cmd0);
    assign add_c = op_inc | ((op_addc | op_subb) & psw_c);

    // split at bits 3 and 6 so ac and ov fall out of the carries
    always_comb begin
        if (op_subb) begin
            low_sum = {1'b0, acc[3:0]} - {1'b0, add_b[3:0]} - {4'b0, add_c};
            mid_sum = {1'b0, acc[6:4]} - {1'b0, add_b[6:4]} - {3'b0, low_sum[4]};
            top_sum = {1'b0, acc[7]} - {1'b0, add_b[7]} - {1'b0, mid_sum[3]};
        end else begin
            low_sum = {1'b0, acc[3:0]} + {1'b0, add_b[3:0]} + {4'b0, add_c};
            mid_sum = {1'b0, acc[6:4]} + {1'b0, add_b[6:4]} + {3'b0, low_sum[4]};
            top_sum = {1'b0, acc[7]} + {1'b0, add_b[7]} + {1'b0, mid_sum[3]};
        end
    end

    assign add_byte = {top_sum[0], mid_sum[2:0], low_sum[3:0]};
    assign bit_ov   = top_sum[1] ^ mid_sum[3];

    assign and_out = acc & pipe.cmd0;
    assign or_out  = acc | pipe.cmd0;
    assign xor_out = acc ^ pipe.cmd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (pipe.work_en) begin
            if (wr_acc_sfr) begin
                acc <= wr_byte;
            end else if (arith_flags | op_inc) begin
                acc <= add_byte;
            end else if (pipe.cmdb == OP_ANL_IMM) begin
                acc <= and_out;
            end else if (pipe.cmdb == OP_ORL_IMM) begin
                acc <= or_out;
            end else if (pipe.cmdb == OP_XRL_IMM) begin
                acc <= xor_out;
            end else if (pipe.cmdb == OP_CLR_A) begin
                acc <= '0;
            end else if (pipe.cmdb == OP_CPL_A) begin
                acc <= ~acc;
            end else if (pipe.cmdb == OP_MOV_A_IMM) begin
                acc <= pipe.cmd0;
            end else if (pipe.cmdc == OP_MOV_A_DIR) begin
                acc <= data0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            psw_c     <= 1'b0;
            psw_ac    <= 1'b0;
            psw_ov    <= 1'b0;
            psw_other <= '0;
        end else if (pipe.work_en) begin
            if (wr_psw_sfr) begin
                psw_c     <= wr_byte[PSW_C];
                psw_ac    <= wr_byte[PSW_AC];
                psw_ov    <= wr_byte[PSW_OV];
                psw_other <= {wr_byte[5:3], wr_byte[1]};
            end else if (arith_flags) begin
                psw_c  <= top_sum[1];
                psw_ac <= low_sum[4];
                psw_ov <= bit_ov;
            end else if (pipe.cmdb == OP_CLR_C) begin
                psw_c <= 1'b0;
            end else if (pipe.cmdb == OP_SETB_C) begin
                psw_c <= 1'b1;
            end
        end
    end

    // f0, rs1, rs0 and f1 are plain storage here
    always_comb begin
        psw         = '0;
        psw[PSW_C]  = psw_c;
        psw[PSW_AC] = psw_ac;
        psw[5:3]    = psw_other[3:1];
        psw[PSW_OV] = psw_ov;
        psw[1]      = psw_other[0];
        psw[PSW_P]  = ^acc;
    end

endmodule

// ==== r8051.sv ====
`timescale 1ns/1ps

module r8051 import r8051_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_en,
    input  logic       cpu_restart,

    output logic       rom_en,
    output code_addr_t rom_addr,
    input  byte_t      rom_byte,

    output logic       ram_rd_en_data,
    output logic       ram_rd_en_sfr,
    output data_addr_t ram_rd_addr,
    input  byte_t      ram_rd_byte,
    input  logic       ram_rd_vld,

    output logic       ram_wr_en_data,
    output logic       ram_wr_en_sfr,
    output data_addr_t ram_wr_addr,
    output byte_t      ram_wr_byte
);

    byte_t acc;
    byte_t psw;
    byte_t data0;
    byte_t wr_byte;
    logic  wr_acc_sfr;
    logic  wr_psw_sfr;
    logic  psw_c;
    logic  ram_rd_req;

    pipe_if pipe ();

    // any issued read starts the wait
    assign ram_rd_req = ram_rd_en_data | ram_rd_en_sfr;

    r8051_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .cpu_en      (cpu_en),
        .cpu_restart (cpu_restart),
        .rom_byte    (rom_byte),
        .ram_rd_req  (ram_rd_req),
        .ram_rd_vld  (ram_rd_vld),
        .psw_c       (psw_c),
        .rom_en      (rom_en),
        .rom_addr    (rom_addr),
        .pipe        (pipe.fetch)
    );

    r8051_mem_access u_mem_access (
        .clk            (clk),
        .rst            (rst),
        .pipe           (pipe.stage),
        .acc            (acc),
        .psw            (psw),
        .ram_rd_byte    (ram_rd_byte),
        .ram_rd_en_data (ram_rd_en_data),
        .ram_rd_en_sfr  (ram_rd_en_sfr),
        .ram_wr_en_data (ram_wr_en_data),
        .ram_wr_en_sfr  (ram_wr_en_sfr),
        .ram_rd_addr    (ram_rd_addr),
        .ram_wr_addr    (ram_wr_addr),
        .ram_wr_byte    (ram_wr_byte),
        .data0          (data0),
        .wr_byte        (wr_byte),
        .wr_acc_sfr     (wr_acc_sfr),
        .wr_psw_sfr     (wr_psw_sfr)
    );

    r8051_exec u_exec (
        .clk        (clk),
        .rst        (rst),
        .pipe       (pipe.stage),
        .data0      (data0),
        .wr_byte    (wr_byte),
        .wr_acc_sfr (wr_acc_sfr),
        .wr_psw_sfr (wr_psw_sfr),
        .acc        (acc),
        .psw        (psw),
        .psw_c      (psw_c)
    );

endmodule

// ==== tb_r8051.sv ====
`timescale 1ns/1ps

module tb_r8051 import r8051_pkg::*; ();

    localparam int PROG_LEN     = 93;
    localparam int N_WRITES     = 15;
    localparam int RESET_CYCLES = 4;
    localparam int TAIL_CYCLES  = 20;
    localparam int CYCLE_LIMIT  = 20 * PROG_LEN;
    localparam int RAND_SEED    = 32'h7493;

    // code image, one instruction per line
    localparam byte_t PROGRAM [PROG_LEN] = '{
        OP_MOV_A_IMM, 8'h3C,
        OP_ANL_IMM, 8'h0F,
        OP_ORL_IMM, 8'hA0,
        OP_XRL_IMM, 8'hFF,
        OP_MOV_DIR_A, 8'h30,
        OP_CPL_A,
        OP_INC_A,
        OP_MOV_DIR_A, 8'h31,
        OP_CLR_A,
        OP_INC_A,
        OP_MOV_DIR_A, 8'h32,
        // psw copied out through acc after each adder op
        OP_MOV_A_IMM, 8'h7A,
        OP_ADD_IMM, 8'h16,
        OP_MOV_DIR_A, 8'h33,
        OP_MOV_A_DIR, SFR_PSW,
        OP_MOV_DIR_A, 8'h34,
        OP_MOV_A_IMM, 8'hFF,
        OP_ADDC_IMM, 8'h01,
        OP_MOV_A_DIR, SFR_PSW,
        OP_MOV_DIR_A, 8'h35,
        OP_MOV_A_IMM, 8'h50,
        OP_SUBB_IMM, 8'h60,
        OP_MOV_DIR_A, 8'h36,
        OP_MOV_A_DIR, SFR_PSW,
        OP_MOV_DIR_A, 8'h37,
        // reads of seeded data memory
        OP_MOV_A_IMM, 8'h11,
        OP_ADD_DIR, 8'h21,
        OP_MOV_DIR_A, 8'h38,
        OP_MOV_A_DIR, 8'h21,
        OP_MOV_DIR_A, 8'h39,
        // store then load of the same address
        OP_MOV_A_IMM, 8'hC6,
        OP_MOV_DIR_A, 8'h22,
        OP_MOV_A_DIR, 8'h22,
        OP_MOV_DIR_A, 8'h3A,
        OP_MOV_DIR_IMM, SFR_ACC, 8'h5D,
        OP_MOV_DIR_A, 8'h3B,
        // branches skip the nop and the store behind them
        OP_CLR_C,
        OP_JC, 8'h03,
        OP_NOP,
        OP_MOV_DIR_A, 8'h3C,
        OP_SETB_C,
        OP_JC, 8'h03,
        OP_NOP,
        OP_MOV_DIR_A, 8'h3D,
        OP_CLR_C,
        OP_JNC, 8'h03,
        OP_NOP,
        OP_MOV_DIR_A, 8'h3E,
        OP_SETB_C,
        OP_JNC, 8'h03,
        OP_NOP,
        OP_MOV_DIR_A, 8'h3F
    };

    // data writes in the order they must appear
    localparam data_addr_t EXP_ADDR [N_WRITES] = '{
        8'h30, 8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36, 8'h37,
        8'h38, 8'h39, 8'h22, 8'h3A, 8'h3B, 8'h3C, 8'h3F
    };
    localparam byte_t EXP_BYTE [N_WRITES] = '{
        8'h53, 8'hAD, 8'h01, 8'h90, 8'h44, 8'hC0, 8'hEF, 8'hC1,
        8'h8C, 8'h7B, 8'hC6, 8'hC6, 8'h5D, 8'h5D, 8'h5D
    };

    logic       clk;
    logic       rst;
    logic       cpu_en;
    logic       cpu_restart;
    logic       rom_en;
    code_addr_t rom_addr;
    byte_t      rom_byte;
    logic       ram_rd_en_data;
    logic       ram_rd_en_sfr;
    data_addr_t ram_rd_addr;
    byte_t      ram_rd_byte;
    logic       ram_rd_vld;
    logic       ram_wr_en_data;
    logic       ram_wr_en_sfr;
    data_addr_t ram_wr_addr;
    byte_t      ram_wr_byte;

    byte_t      data_mem [256];
    logic       fetch_en;
    code_addr_t fetch_addr;
    logic       rd_pending;
    int         rd_delay;
    data_addr_t rd_addr_q;
    int         wr_count;
    int         cycle_count;

    r8051 UUT (
        .clk            (clk),
        .rst            (rst),
        .cpu_en         (cpu_en),
        .cpu_restart    (cpu_restart),
        .rom_en         (rom_en),
        .rom_addr       (rom_addr),
        .rom_byte       (rom_byte),
        .ram_rd_en_data (ram_rd_en_data),
        .ram_rd_en_sfr  (ram_rd_en_sfr),
        .ram_rd_addr    (ram_rd_addr),
        .ram_rd_byte    (ram_rd_byte),
        .ram_rd_vld     (ram_rd_vld),
        .ram_wr_en_data (ram_wr_en_data),
        .ram_wr_en_sfr  (ram_wr_en_sfr),
        .ram_wr_addr    (ram_wr_addr),
        .ram_wr_byte    (ram_wr_byte)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_addr(input string name, input data_addr_t got,
                              input data_addr_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("mismatch %s: got %h, expected %h",
                                        name, got, expected));
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("mismatch %s: got %h, expected %h",
                                        name, got, expected));
        end
    endtask

    function automatic byte_t rom_lookup(input code_addr_t addr);
        // past the program the core runs on nops
        if (int'(addr) < PROG_LEN) begin
            return PROGRAM[addr];
        end
        return OP_NOP;
    endfunction

    // rom and data memory models sample the outputs mid-cycle
    initial begin
        rom_byte    = '0;
        ram_rd_vld  = 1'b0;
        ram_rd_byte = '0;
        fetch_en    = 1'b0;
        fetch_addr  = '0;
        rd_pending  = 1'b0;
        rd_delay    = 0;
        rd_addr_q   = '0;
        wr_count    = 0;
        void'($urandom(RAND_SEED));
        for (int i = 0; i < 256; i++) begin
            data_mem[i] = byte_t'(i) ^ 8'h5A;
        end
        forever begin
            @(negedge clk);
            fetch_en   = rom_en;
            fetch_addr = rom_addr;
            if (ram_rd_en_sfr) begin
                stop_with_failure("read appeared on the sfr bus");
            end
            if (ram_wr_en_sfr) begin
                stop_with_failure("write appeared on the sfr bus");
            end
            if (ram_wr_en_data) begin
                if (wr_count >= N_WRITES) begin
                    stop_with_failure("data write after the last expected write");
                end else begin
                    check_addr("ram_wr_addr", ram_wr_addr, EXP_ADDR[wr_count]);
                    check_byte("ram_wr_byte", ram_wr_byte, EXP_BYTE[wr_count]);
                    data_mem[ram_wr_addr] = ram_wr_byte;
                    wr_count = wr_count + 1;
                end
            end
            if (ram_rd_en_data) begin
                if (rd_pending) begin
                    stop_with_failure("read issued while another read was pending");
                end else begin
                    rd_pending = 1'b1;
                    rd_addr_q  = ram_rd_addr;
                    rd_delay   = $urandom % 4;
                end
            end
            @(posedge clk);
            // inputs change just after the edge
            #0.5;
            if (fetch_en) begin
                rom_byte = rom_lookup(fetch_addr);
            end
            ram_rd_vld = 1'b0;
            if (rd_pending) begin
                if (rd_delay == 0) begin
                    ram_rd_vld  = 1'b1;
                    ram_rd_byte = data_mem[rd_addr_q];
                    rd_pending  = 1'b0;
                end else begin
                    rd_delay = rd_delay - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= CYCLE_LIMIT) begin
                stop_with_failure($sformatf("run did not finish within %0d cycles",
                                            CYCLE_LIMIT));
            end
        end
    end

    initial begin
        rst         = 1'b1;
        cpu_en      = 1'b0;
        cpu_restart = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        rst    = 1'b0;
        cpu_en = 1'b1;
        wait (wr_count == N_WRITES);
        // room for a stray write to show up
        repeat (TAIL_CYCLES) @(posedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== r8051.f ====
r8051_pkg.sv
r8051_pipe_if.sv
r8051_fetch.sv
r8051_mem_access.sv
r8051_exec.sv
r8051.sv
tb_r8051.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_r8051 \
    -f r8051.f -o tb_r8051
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_r8051
if [ $? -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi

exit 0
